/* src/rename_pkg.sv */
/*
 * Sizes, widths and index types shared by the rename core.
 * Every RTL block and the testbench import this package.
 */

package rename_pkg;

  // architectural and physical register counts
  localparam int num_arch = 32;
  localparam int num_phys = 64;

  // reorder buffer depth; power of two so pointers wrap on their own
  localparam int num_rob = 16;

  // tags not held by the map at reset
  localparam int num_free = num_phys - num_arch;

  localparam int arch_w = $clog2(num_arch);
  localparam int tag_w  = $clog2(num_phys);
  localparam int rob_w  = $clog2(num_rob);

  // free list pointer width, power of two as well
  localparam int free_w = $clog2(num_free);

  typedef logic [arch_w-1:0] arch_reg_t;
  typedef logic [tag_w-1:0]  phys_tag_t;
  typedef logic [rob_w-1:0]  rob_idx_t;

endpackage

/* src/free_list.sv */
/*
 * Circular queue of free physical tags. Pops one tag per dispatch,
 * takes back T_old on retire, and steps its read pointer back one
 * slot for each entry undone by a mispredict rewind.
 */

`timescale 1ns/10ps

module free_list import rename_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      pop,
  input  logic      push,
  input  phys_tag_t push_tag,
  input  logic      unpop,
  output phys_tag_t tag,
  output logic      empty
);

  phys_tag_t           tags_q [num_free];
  logic [free_w-1:0]   rd_ptr_q;
  logic [free_w-1:0]   wr_ptr_q;
  logic [free_w:0]     count_q;
  logic [free_w:0]     count_next;

  // head of the queue is the next tag handed out
  assign tag   = tags_q[rd_ptr_q];
  assign empty = (count_q == '0);

  // pop never meets unpop, since dispatch is held off while rewinding
  always_comb begin
    count_next = count_q;
    if (pop) begin
      count_next = count_next - 1'b1;
    end
    if (push) begin
      count_next = count_next + 1'b1;
    end
    if (unpop) begin
      count_next = count_next + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= num_free[free_w:0];
      // tags above the identity mapping start out free, in order
      for (int i = 0; i < num_free; i++) begin
        tags_q[i] <= phys_tag_t'(num_arch + i);
      end
    end else begin
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // the slot behind the read pointer still holds the popped tag
      if (unpop) begin
        rd_ptr_q <= rd_ptr_q - 1'b1;
      end
      if (push) begin
        tags_q[wr_ptr_q] <= push_tag;
        wr_ptr_q         <= wr_ptr_q + 1'b1;
      end
      count_q <= count_next;
    end
  end

endmodule

/* src/map_table.sv */
/*
 * Speculative architectural-to-physical map. Read combinationally at
 * dispatch for T_old, written with the new tag on the same edge, and
 * restored to T_old one entry at a time during a rewind.
 */

`timescale 1ns/10ps

module map_table import rename_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  arch_reg_t read_reg,
  output phys_tag_t old_tag,
  input  logic      write,
  input  arch_reg_t write_reg,
  input  phys_tag_t write_tag,
  input  logic      restore,
  input  arch_reg_t restore_reg,
  input  phys_tag_t restore_tag
);

  phys_tag_t map_q [num_arch];

  // current mapping, before this cycle's write lands
  assign old_tag = map_q[read_reg];

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map out of reset
      for (int i = 0; i < num_arch; i++) begin
        map_q[i] <= phys_tag_t'(i);
      end
    end else begin
      if (write) begin
        map_q[write_reg] <= write_tag;
      end
      // dispatch is stalled during rewind so these never overlap
      if (restore) begin
        map_q[restore_reg] <= restore_tag;
      end
    end
  end

endmodule

/* src/rob.sv */
/*
 * Reorder buffer holding register, T and T_old per entry between head
 * and tail. Retires from the head and undoes a mispredict by walking
 * the tail back one entry per cycle through the tail-minus-one port.
 */

`timescale 1ns/10ps

module rob import rename_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      write,
  input  arch_reg_t write_reg,
  input  phys_tag_t write_tag,
  input  phys_tag_t write_old_tag,
  output rob_idx_t  tail_idx,
  output logic      full,
  input  logic      retire,
  output logic      retire_valid,
  output arch_reg_t retire_reg,
  output phys_tag_t retire_tag,
  output phys_tag_t retire_old_tag,
  output rob_idx_t  head_idx,
  input  logic      mispredict,
  input  rob_idx_t  branch_idx,
  output logic      rewinding,
  output logic      rewind_step,
  output arch_reg_t rewind_reg,
  output phys_tag_t rewind_tag,
  output phys_tag_t rewind_old_tag
);

  logic [num_rob-1:0] valid_q;
  arch_reg_t          reg_q [num_rob];
  phys_tag_t          tag_q [num_rob];
  phys_tag_t          old_tag_q [num_rob];

  rob_idx_t head_q;
  rob_idx_t tail_q;
  rob_idx_t tail_m1;
  rob_idx_t stop_q;
  logic     rewind_q;
  logic     rewind_start;
  logic     rewind_done;
  logic     retire_fire;

  assign tail_m1  = tail_q - 1'b1;
  assign tail_idx = tail_q;
  assign head_idx = head_q;

  // next slot still occupied means all entries are live
  assign full = valid_q[tail_q];

  // only a valid branch starts a rewind, and never a second one
  assign rewind_start = mispredict && valid_q[branch_idx] && !rewind_q;

  // stop_q is the first entry after the branch
  assign rewind_step = rewind_q && (tail_q != stop_q);
  assign rewind_done = !rewind_step || (tail_m1 == stop_q);

  // head must not run into the squashed region while it is undone
  assign retire_fire = retire && valid_q[head_q] && !(rewind_step && head_q == stop_q);

  assign retire_valid   = retire_fire;
  assign retire_reg     = reg_q[head_q];
  assign retire_tag     = tag_q[head_q];
  assign retire_old_tag = old_tag_q[head_q];

  // youngest entry, undone on each rewind step
  assign rewinding      = rewind_q;
  assign rewind_reg     = reg_q[tail_m1];
  assign rewind_tag     = tag_q[tail_m1];
  assign rewind_old_tag = old_tag_q[tail_m1];

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q   <= '0;
      tail_q   <= '0;
      stop_q   <= '0;
      valid_q  <= '0;
      rewind_q <= 1'b0;
    end else begin
      // write is held off while full or rewinding
      if (write) begin
        valid_q[tail_q] <= 1'b1;
        tail_q          <= tail_q + 1'b1;
      end
      if (retire_fire) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_q + 1'b1;
      end
      if (rewind_step) begin
        valid_q[tail_m1] <= 1'b0;
        tail_q           <= tail_m1;
      end
      if (rewind_start) begin
        rewind_q <= 1'b1;
        stop_q   <= branch_idx + 1'b1;
      end else if (rewind_q && rewind_done) begin
        rewind_q <= 1'b0;
      end
    end
  end

  // entry payload
  always_ff @(posedge clock) begin
    if (write) begin
      reg_q[tail_q]     <= write_reg;
      tag_q[tail_q]     <= write_tag;
      old_tag_q[tail_q] <= write_old_tag;
    end
  end

endmodule

/* src/rename_core.sv */
/*
 * Rename and retire core: free list, map table and reorder buffer
 * wired for one dispatch and one retire per cycle. Dispatch is
 * refused through stall while any block cannot take it.
 */

`timescale 1ns/10ps

module rename_core import rename_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      dispatch,
  input  arch_reg_t dest_reg,
  input  logic      retire,
  input  logic      mispredict,
  input  rob_idx_t  branch_idx,
  output logic      stall,
  output phys_tag_t disp_tag,
  output phys_tag_t disp_old_tag,
  output rob_idx_t  disp_rob_idx,
  output logic      retire_valid,
  output arch_reg_t retire_reg,
  output phys_tag_t retire_tag,
  output phys_tag_t retire_old_tag,
  output logic      rewinding,
  output rob_idx_t  head_idx
);

  logic      dispatch_fire;
  logic      rob_full;
  logic      free_empty;
  logic      rewind_step;
  arch_reg_t rewind_reg;
  // tag handed back by each step, matches the free list slot behind rd_ptr
  phys_tag_t rewind_tag;
  phys_tag_t rewind_old_tag;

  assign stall         = rob_full || free_empty || rewinding;
  assign dispatch_fire = dispatch && !stall;

  free_list i_free_list (
    .clock    (clock),
    .reset    (reset),
    .pop      (dispatch_fire),
    .push     (retire_valid),
    .push_tag (retire_old_tag),
    .unpop    (rewind_step),
    .tag      (disp_tag),
    .empty    (free_empty)
  );

  map_table i_map_table (
    .clock       (clock),
    .reset       (reset),
    .read_reg    (dest_reg),
    .old_tag     (disp_old_tag),
    .write       (dispatch_fire),
    .write_reg   (dest_reg),
    .write_tag   (disp_tag),
    .restore     (rewind_step),
    .restore_reg (rewind_reg),
    .restore_tag (rewind_old_tag)
  );

  rob i_rob (
    .clock          (clock),
    .reset          (reset),
    .write          (dispatch_fire),
    .write_reg      (dest_reg),
    .write_tag      (disp_tag),
    .write_old_tag  (disp_old_tag),
    .tail_idx       (disp_rob_idx),
    .full           (rob_full),
    .retire         (retire),
    .retire_valid   (retire_valid),
    .retire_reg     (retire_reg),
    .retire_tag     (retire_tag),
    .retire_old_tag (retire_old_tag),
    .head_idx       (head_idx),
    .mispredict     (mispredict),
    .branch_idx     (branch_idx),
    .rewinding      (rewinding),
    .rewind_step    (rewind_step),
    .rewind_reg     (rewind_reg),
    .rewind_tag     (rewind_tag),
    .rewind_old_tag (rewind_old_tag)
  );

endmodule

/* test/rename_core_properties.sv */
/*
 * Concurrent checks on the stall, dispatch and rewind control of the
 * rename core. Attached to rename_core with bind.
 */

`timescale 1ns/10ps

module rename_core_properties import rename_pkg::*; (
  input logic      clock,
  input logic      reset,
  input logic      stall,
  input logic      rewinding,
  input logic      rewind_step,
  input phys_tag_t rewind_tag,
  input logic      dispatch_fire,
  input logic      mispredict,
  input rob_idx_t  branch_idx,
  input logic      retire_valid,
  input phys_tag_t disp_tag,
  input rob_idx_t  disp_rob_idx,
  input rob_idx_t  head_idx
);

  int unsigned    fail_count = 0;
  logic [rob_w:0] live_q;
  rob_idx_t       branch_offset;
  logic           branch_live;

  // live entries, followed through the dispatch, retire and step strobes
  always_ff @(posedge clock) begin
    if (reset) begin
      live_q <= '0;
    end else begin
      live_q <= live_q + {{rob_w{1'b0}}, dispatch_fire}
                - {{rob_w{1'b0}}, retire_valid} - {{rob_w{1'b0}}, rewind_step};
    end
  end

  // branch lies between head and tail
  assign branch_offset = branch_idx - head_idx;
  assign branch_live   = {1'b0, branch_offset} < live_q;

  // a full buffer or a rewind must hold dispatch off
  stall_on_hazard: assert property (@(posedge clock) disable iff (reset)
    (live_q == (rob_w + 1)'(num_rob) || rewinding) |-> stall)
  else begin
    $error("stall low while the buffer is full or rewinding is high");
    fail_count++;
  end

  // only a mispredict on a live entry starts a rewind
  rewind_from_mispredict: assert property (@(posedge clock) disable iff (reset)
    !rewinding |=> (rewinding == $past(mispredict && branch_live)))
  else begin
    $error("rewinding does not follow a mispredict on a live entry");
    fail_count++;
  end

  // undone tag is the next one handed out
  step_returns_tag: assert property (@(posedge clock) disable iff (reset)
    rewind_step |=> (disp_tag == $past(rewind_tag)))
  else begin
    $error("tag undone by a rewind step is not back at the free list head");
    fail_count++;
  end

  // a refused dispatch leaves the tail where it was
  tail_held_on_stall: assert property (@(posedge clock) disable iff (reset)
    (stall && !rewind_step) |=> (disp_rob_idx == $past(disp_rob_idx)))
  else begin
    $error("tail moved while dispatch was stalled");
    fail_count++;
  end

  no_retire_when_empty: assert property (@(posedge clock) disable iff (reset)
    (live_q == '0) |-> !retire_valid)
  else begin
    $error("retire_valid while the reorder buffer is empty");
    fail_count++;
  end

endmodule

bind rename_core rename_core_properties i_props (
  .clock         (clock),
  .reset         (reset),
  .stall         (stall),
  .rewinding     (rewinding),
  .rewind_step   (rewind_step),
  .rewind_tag    (rewind_tag),
  .dispatch_fire (dispatch_fire),
  .mispredict    (mispredict),
  .branch_idx    (branch_idx),
  .retire_valid  (retire_valid),
  .disp_tag      (disp_tag),
  .disp_rob_idx  (disp_rob_idx),
  .head_idx      (head_idx)
);

/* test/rename_core_tb.sv */
/*
 * Self-checking testbench for rename_core. Directed fill, rewind and
 * drain cases, then random dispatch, retire and mispredict traffic,
 * compared each cycle with a model of free tags, map and reorder buffer.
 */

`timescale 1ns/10ps

module rename_core_tb import rename_pkg::*; ();

  localparam int clock_period    = 8;
  localparam int random_cycles   = 1500;
  localparam int directed_cycles = 200;
  localparam int rewind_limit    = num_rob + 4;

  logic      clock;
  logic      reset;
  logic      dispatch;
  arch_reg_t dest_reg;
  logic      retire;
  logic      mispredict;
  rob_idx_t  branch_idx;
  logic      stall;
  phys_tag_t disp_tag;
  phys_tag_t disp_old_tag;
  rob_idx_t  disp_rob_idx;
  logic      retire_valid;
  arch_reg_t retire_reg;
  phys_tag_t retire_tag;
  phys_tag_t retire_old_tag;
  logic      rewinding;
  rob_idx_t  head_idx;

  // model state
  phys_tag_t free_m [$];
  phys_tag_t map_m [num_arch];
  arch_reg_t rob_reg_m [$];
  phys_tag_t rob_tag_m [$];
  phys_tag_t rob_old_m [$];
  rob_idx_t  head_m;
  rob_idx_t  tail_m;
  rob_idx_t  stop_m;
  rob_idx_t  last_branch;
  logic      rewinding_m;
  logic      check_branch_slot;
  int        model_errors;

  rename_core i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  initial begin
    #((5 + directed_cycles + random_cycles + 100) * clock_period);
    $display("watchdog expired before the stimulus finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      model_errors++;
    end
  endtask

  task automatic reset_model();
    free_m.delete();
    rob_reg_m.delete();
    rob_tag_m.delete();
    rob_old_m.delete();
    for (int i = 0; i < num_free; i++) begin
      free_m.push_back(phys_tag_t'(num_arch + i));
    end
    for (int i = 0; i < num_arch; i++) begin
      map_m[i] = phys_tag_t'(i);
    end
    head_m            = '0;
    tail_m            = '0;
    stop_m            = '0;
    last_branch       = '0;
    rewinding_m       = 1'b0;
    check_branch_slot = 1'b0;
  endtask

  // entry is live if it lies between head and tail
  function automatic logic is_live(input rob_idx_t idx);
    rob_idx_t offset;
    offset = idx - head_m;
    return int'(offset) < rob_reg_m.size();
  endfunction

  // compare outputs, then advance the model across the coming edge
  task automatic check_cycle();
    logic      exp_stall;
    logic      step;
    logic      exp_retire;
    logic      fire;
    logic      live;
    rob_idx_t  tail_before;
    arch_reg_t undo_reg;
    phys_tag_t undo_tag;
    phys_tag_t undo_old;
    exp_stall   = rob_reg_m.size() == num_rob || free_m.size() == 0 || rewinding_m;
    step        = rewinding_m && tail_m != stop_m;
    // squashed head entries never retire
    exp_retire  = retire && rob_reg_m.size() > 0 && !(step && head_m == stop_m);
    fire        = dispatch && !exp_stall;
    live        = is_live(branch_idx);
    tail_before = tail_m;
    check_value("stall", stall, exp_stall);
    check_value("rewinding", rewinding, rewinding_m);
    check_value("retire_valid", retire_valid, exp_retire);
    check_value("head_idx", head_idx, head_m);
    check_value("disp_rob_idx", disp_rob_idx, tail_m);
    check_value("disp_old_tag", disp_old_tag, map_m[dest_reg]);
    if (free_m.size() > 0) begin
      check_value("disp_tag", disp_tag, free_m[0]);
    end
    if (exp_retire) begin
      check_value("retire_reg", retire_reg, rob_reg_m[0]);
      check_value("retire_tag", retire_tag, rob_tag_m[0]);
      check_value("retire_old_tag", retire_old_tag, rob_old_m[0]);
      free_m.push_back(rob_old_m[0]);
      void'(rob_reg_m.pop_front());
      void'(rob_tag_m.pop_front());
      void'(rob_old_m.pop_front());
      head_m = head_m + 1'b1;
    end
    if (fire) begin
      if (check_branch_slot) begin
        check_value("disp_rob_idx after rewind", disp_rob_idx, rob_idx_t'(last_branch + 1'b1));
        check_branch_slot = 1'b0;
      end
      rob_reg_m.push_back(dest_reg);
      rob_tag_m.push_back(free_m[0]);
      rob_old_m.push_back(map_m[dest_reg]);
      map_m[dest_reg] = free_m[0];
      void'(free_m.pop_front());
      tail_m = tail_m + 1'b1;
    end
    // undo the youngest entry; its tag is next to be handed out again
    if (step) begin
      undo_reg = rob_reg_m.pop_back();
      undo_tag = rob_tag_m.pop_back();
      undo_old = rob_old_m.pop_back();
      map_m[undo_reg] = undo_old;
      free_m.push_front(undo_tag);
      tail_m = tail_m - 1'b1;
    end
    if (rewinding_m) begin
      if (!step || rob_idx_t'(tail_before - 1'b1) == stop_m) begin
        rewinding_m       = 1'b0;
        check_branch_slot = 1'b1;
      end
    end else if (mispredict && live) begin
      rewinding_m = 1'b1;
      stop_m      = branch_idx + 1'b1;
      last_branch = branch_idx;
    end
  endtask

  task automatic drive(input logic d, input arch_reg_t rd, input logic r,
                       input logic m, input rob_idx_t idx);
    @(posedge clock);
    dispatch   <= d;
    dest_reg   <= rd;
    retire     <= r;
    mispredict <= m;
    branch_idx <= idx;
    @(negedge clock);
    check_cycle();
  endtask

  task automatic wait_rewind();
    int n;
    n = 0;
    do begin
      drive(1'b0, '0, 1'b0, 1'b0, '0);
      n++;
    end while (rewinding && n < rewind_limit);
    if (rewinding) begin
      $display("rewind did not finish within %0d cycles", rewind_limit);
      model_errors++;
    end
  endtask

  task automatic drain_rob();
    int n;
    n = 0;
    while (rob_reg_m.size() > 0 && n < 2 * num_rob) begin
      drive(1'b0, '0, 1'b1, 1'b0, '0);
      n++;
    end
    if (rob_reg_m.size() > 0) begin
      $display("reorder buffer did not drain");
      model_errors++;
    end
  endtask

  task automatic random_cycle();
    logic     d;
    logic     r;
    logic     m;
    rob_idx_t idx;
    d = ($urandom % 100) < 60;
    r = ($urandom % 100) < 40;
    m = ($urandom % 100) < 4;
    // mostly live branches, some stray indices
    if (rob_reg_m.size() > 0 && ($urandom % 4) != 0) begin
      idx = head_m + rob_idx_t'($urandom % rob_reg_m.size());
    end else begin
      idx = rob_idx_t'($urandom);
    end
    drive(d, arch_reg_t'($urandom), r, m, idx);
  endtask

  initial begin
    int prop_errors;
    void'($urandom(32'ha71a));
    reset        = 1'b1;
    dispatch     = 1'b0;
    dest_reg     = '0;
    retire       = 1'b0;
    mispredict   = 1'b0;
    branch_idx   = '0;
    model_errors = 0;
    reset_model();
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_cycle();

    // fill past capacity, last two dispatches meet a full buffer
    for (int i = 0; i < num_rob + 2; i++) begin
      drive(1'b1, arch_reg_t'(i % 5), 1'b0, 1'b0, '0);
    end
    drive(1'b0, '0, 1'b0, 1'b1, rob_idx_t'(head_m + 3));
    wait_rewind();
    drive(1'b1, arch_reg_t'(2), 1'b0, 1'b0, '0);
    drain_rob();

    // empty buffer: stray mispredict and retire do nothing
    drive(1'b0, '0, 1'b1, 1'b1, tail_m);
    drive(1'b0, '0, 1'b1, 1'b0, '0);

    for (int i = 0; i < random_cycles; i++) begin
      random_cycle();
    end
    wait_rewind();
    drain_rob();

    prop_errors = i_dut.i_props.fail_count;
    $display("errors: %0d model, %0d assertion", model_errors, prop_errors);
    if (model_errors == 0 && prop_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* rename_core.f */
src/rename_pkg.sv
src/free_list.sv
src/map_table.sv
src/rob.sv
src/rename_core.sv
test/rename_core_properties.sv
test/rename_core_tb.sv

/* Makefile */
# Verilator build and run for the rename core testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := rename_core_tb
FILELIST  := rename_core.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
SIM_ARGS  := +verilator+error+limit+1000
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	$(SIM) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^ALL TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
